// ==== fpu_ss_pkg.sv ====
// Single-precision subset only: no rounding modes, no status flags, full-word memory accesses
`default_nettype none

package fpu_ss_pkg;

  // --------------------------------------------------
  // Widths and sizes
  // --------------------------------------------------
  localparam int XLEN             = 32;
  localparam int NUM_FPR          = 32;
  localparam int REG_ADDR_W       = 5;
  localparam int ID_W             = 4;
  localparam int LOAD_QUEUE_DEPTH = 2;
  localparam int LQ_PTR_W         = (LOAD_QUEUE_DEPTH > 1) ? $clog2(LOAD_QUEUE_DEPTH) : 1;

  // RV32F major opcodes
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
  localparam logic [6:0] OPC_OP_FP    = 7'b1010011;

  // funct7 with fmt = S
  localparam logic [6:0] F7_SGNJ    = 7'b0010000;
  localparam logic [6:0] F7_FMV_X_W = 7'b1110000;
  localparam logic [6:0] F7_FMV_W_X = 7'b1111000;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX,
    OP_FMV_X_W,
    OP_FMV_W_X,
    OP_LOAD,
    OP_STORE
  } fpu_op_e;

  // --------------------------------------------------
  // Payload structs
  // --------------------------------------------------
  typedef struct packed {
    fpu_op_e               op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  we_fp;
  } decoded_t;

  typedef struct packed {
    logic [XLEN-1:0]       instr;
    logic [1:0][XLEN-1:0]  rs;
    logic [ID_W-1:0]       id;
  } issue_req_t;

  typedef struct packed {
    logic accept;
  } issue_resp_t;

  typedef struct packed {
    fpu_op_e               op;
    logic [REG_ADDR_W-1:0] rd;
    logic [ID_W-1:0]       id;
    logic [1:0][XLEN-1:0]  operands;
  } exec_req_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } wb_req_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            we;
  } mem_req_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [XLEN-1:0] rdata;
  } mem_result_t;

  typedef struct packed {
    logic [ID_W-1:0]       id;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } result_t;

endpackage

`default_nettype wire

// ==== fpu_ss_wb_arbiter.sv ====
// Fixed priority with the LSU on top; the execution unit may wait indefinitely under load traffic
`timescale 1ns/1ps
`default_nettype none

module fpu_ss_wb_arbiter (
  input  logic                lsu_valid_i,
  input  fpu_ss_pkg::wb_req_t lsu_req_i,
  input  logic                exec_valid_i,
  input  fpu_ss_pkg::wb_req_t exec_req_i,
  output logic                exec_grant_o,
  output logic                wb_valid_o,
  output fpu_ss_pkg::wb_req_t wb_req_o
);

  // Memory results cannot be held back
  assign exec_grant_o = exec_valid_i & ~lsu_valid_i;
  assign wb_valid_o   = lsu_valid_i | exec_valid_i;
  assign wb_req_o     = lsu_valid_i ? lsu_req_i : exec_req_i;

endmodule

`default_nettype wire

// ==== fpu_ss_regfile.sv ====
// Flop-based FP registers with asynchronous read; one write per cycle
`timescale 1ns/1ps
`default_nettype none

module fpu_ss_regfile (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic [fpu_ss_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [fpu_ss_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [fpu_ss_pkg::XLEN-1:0]       rdata_a_o,
  output logic [fpu_ss_pkg::XLEN-1:0]       rdata_b_o,
  input  logic                              wb_valid_i,
  input  fpu_ss_pkg::wb_req_t               wb_req_i
);

  import fpu_ss_pkg::*;

  logic [NUM_FPR-1:0][XLEN-1:0] regs_q;

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      regs_q <= '0;
    end else if (wb_valid_i) begin
      regs_q[wb_req_i.addr] <= wb_req_i.data;
    end
  end

endmodule

`default_nettype wire

// ==== fpu_ss_decoder.sv ====
// Decodes only flw/fsw, fsgnj*.s and fmv between X and F; everything else is rejected
`timescale 1ns/1ps
`default_nettype none

module fpu_ss_decoder (
  input  logic [fpu_ss_pkg::XLEN-1:0] instr_i,
  output fpu_ss_pkg::decoded_t        decoded_o,
  output logic                        accept_o
);

  import fpu_ss_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    decoded_o     = '0;
    decoded_o.op  = OP_NONE;
    decoded_o.rd  = instr_i[11:7];
    decoded_o.rs1 = instr_i[19:15];
    decoded_o.rs2 = instr_i[24:20];

    case (opcode)
      OPC_LOAD_FP: begin
        // Word width only
        if (funct3 == 3'b010) begin
          decoded_o.op    = OP_LOAD;
          decoded_o.imm   = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
          decoded_o.we_fp = 1'b1;
        end
      end
      OPC_STORE_FP: begin
        if (funct3 == 3'b010) begin
          decoded_o.op      = OP_STORE;
          decoded_o.imm     = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
          decoded_o.use_rs2 = 1'b1;
        end
      end
      OPC_OP_FP: begin
        if (funct7 == F7_SGNJ && funct3 <= 3'b010) begin
          case (funct3)
            3'b000:  decoded_o.op = OP_SGNJ;
            3'b001:  decoded_o.op = OP_SGNJN;
            default: decoded_o.op = OP_SGNJX;
          endcase
          decoded_o.use_rs1 = 1'b1;
          decoded_o.use_rs2 = 1'b1;
          decoded_o.we_fp   = 1'b1;
        end else if (funct7 == F7_FMV_X_W && funct3 == 3'b000 && instr_i[24:20] == '0) begin
          decoded_o.op      = OP_FMV_X_W;
          decoded_o.use_rs1 = 1'b1;
        end else if (funct7 == F7_FMV_W_X && funct3 == 3'b000 && instr_i[24:20] == '0) begin
          // Source comes from the integer operand
          decoded_o.op    = OP_FMV_W_X;
          decoded_o.we_fp = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign accept_o = (decoded_o.op != OP_NONE);

endmodule

`default_nettype wire

// ==== fpu_ss_controller.sv ====
// Stalls issue on any busy FP source or destination; no forwarding, one issue per cycle
`timescale 1ns/1ps
`default_nettype none

module fpu_ss_controller (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  issue_valid_i,
  output logic                                  issue_ready_o,
  input  fpu_ss_pkg::issue_req_t                issue_req_i,
  input  fpu_ss_pkg::decoded_t                  decoded_i,
  input  logic [1:0][fpu_ss_pkg::XLEN-1:0]      fpr_rdata_i,
  input  logic                                  exec_ready_i,
  input  logic                                  lsu_ready_i,
  output fpu_ss_pkg::exec_req_t                 exec_req_o,
  output logic                                  exec_valid_o,
  output logic                                  lsu_valid_o,
  input  logic                                  wb_en_i,
  input  logic [fpu_ss_pkg::REG_ADDR_W-1:0]     wb_addr_i
);

  import fpu_ss_pkg::*;

  logic [NUM_FPR-1:0] busy_q;
  logic               running_q;
  logic               to_exec;
  logic               to_lsu;
  logic               hazard;
  logic               unit_ready;
  logic               fire;

  // --------------------------------------------------
  // Target unit and scoreboard check
  // --------------------------------------------------
  assign to_exec = decoded_i.op inside {OP_SGNJ, OP_SGNJN, OP_SGNJX, OP_FMV_X_W, OP_FMV_W_X};
  assign to_lsu  = decoded_i.op inside {OP_LOAD, OP_STORE};

  assign hazard = (decoded_i.use_rs1 & busy_q[decoded_i.rs1])
                | (decoded_i.use_rs2 & busy_q[decoded_i.rs2])
                | (decoded_i.we_fp   & busy_q[decoded_i.rd]);

  assign unit_ready    = (~to_exec | exec_ready_i) & (~to_lsu | lsu_ready_i);
  assign issue_ready_o = running_q & ~hazard & unit_ready;

  assign fire         = issue_valid_i & issue_ready_o;
  assign exec_valid_o = fire & to_exec;
  assign lsu_valid_o  = fire & to_lsu;

  // Operand 0 is the FP rs1 or the integer rs1, operand 1 is always FP rs2
  always_comb begin
    exec_req_o.op          = decoded_i.op;
    exec_req_o.rd          = decoded_i.rd;
    exec_req_o.id          = issue_req_i.id;
    exec_req_o.operands[0] = decoded_i.use_rs1 ? fpr_rdata_i[0] : issue_req_i.rs[0];
    exec_req_o.operands[1] = fpr_rdata_i[1];
  end

  // --------------------------------------------------
  // Busy bits
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= '0;
      running_q <= 1'b0;
    end else begin
      running_q <= 1'b1;
      if (wb_en_i) begin
        busy_q[wb_addr_i] <= 1'b0;
      end
      // A busy rd blocks issue, so set and clear never hit the same register
      if (fire && decoded_i.we_fp) begin
        busy_q[decoded_i.rd] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== fpu_ss_sgnj_unit.sv ====
// Single-entry stage; takes a new operation only when empty, so issue to it is every other cycle
`timescale 1ns/1ps
`default_nettype none

module fpu_ss_sgnj_unit (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_valid_i,
  input  fpu_ss_pkg::exec_req_t req_i,
  output logic                  ready_o,
  output logic                  wb_valid_o,
  output fpu_ss_pkg::wb_req_t   wb_req_o,
  input  logic                  wb_grant_i,
  output logic                  result_valid_o,
  input  logic                  result_ready_i,
  output fpu_ss_pkg::result_t   result_o
);

  import fpu_ss_pkg::*;

  logic                  full_q;
  logic                  to_fpr_q;
  logic [REG_ADDR_W-1:0] rd_q;
  logic [ID_W-1:0]       id_q;
  logic [XLEN-1:0]       data_q;
  logic [XLEN-1:0]       res;
  logic [XLEN-1:0]       op_a;
  logic [XLEN-1:0]       op_b;
  logic                  drain;

  assign op_a = req_i.operands[0];
  assign op_b = req_i.operands[1];

  // Magnitude from rs1, sign by rule; moves pass the bits
  always_comb begin
    case (req_i.op)
      OP_SGNJ:  res = {op_b[XLEN-1], op_a[XLEN-2:0]};
      OP_SGNJN: res = {~op_b[XLEN-1], op_a[XLEN-2:0]};
      OP_SGNJX: res = {op_a[XLEN-1] ^ op_b[XLEN-1], op_a[XLEN-2:0]};
      default:  res = op_a;
    endcase
  end

  assign ready_o        = ~full_q;
  assign wb_valid_o     = full_q & to_fpr_q;
  assign result_valid_o = full_q & ~to_fpr_q;
  assign drain          = (wb_valid_o & wb_grant_i) | (result_valid_o & result_ready_i);

  assign wb_req_o.addr = rd_q;
  assign wb_req_o.data = data_q;
  assign result_o.id   = id_q;
  assign result_o.rd   = rd_q;
  assign result_o.data = data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (req_valid_i) begin
      full_q <= 1'b1;
    end else if (drain) begin
      full_q <= 1'b0;
    end
  end

  // Entry payload stays put while the entry waits
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      to_fpr_q <= (req_i.op != OP_FMV_X_W);
      rd_q     <= req_i.rd;
      id_q     <= req_i.id;
      data_q   <= res;
    end
  end

endmodule

`default_nettype wire

// ==== fpu_ss_lsu.sv ====
// Loads must return in request order; the memory result id is not checked
`timescale 1ns/1ps
`default_nettype none

module fpu_ss_lsu (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        req_valid_i,
  input  fpu_ss_pkg::exec_req_t       req_i,
  input  logic [fpu_ss_pkg::XLEN-1:0] imm_i,
  output logic                        ready_o,
  output logic                        mem_valid_o,
  input  logic                        mem_ready_i,
  output fpu_ss_pkg::mem_req_t        mem_req_o,
  input  logic                        mem_result_valid_i,
  input  fpu_ss_pkg::mem_result_t     mem_result_i,
  output logic                        wb_valid_o,
  output fpu_ss_pkg::wb_req_t         wb_req_o
);

  import fpu_ss_pkg::*;

  logic                                       req_full_q;
  mem_req_t                                   req_q;
  logic [REG_ADDR_W-1:0]                      req_rd_q;
  logic [LOAD_QUEUE_DEPTH-1:0][REG_ADDR_W-1:0] queue_q;
  logic [LQ_PTR_W-1:0]                        wr_ptr_q;
  logic [LQ_PTR_W-1:0]                        rd_ptr_q;
  logic [LQ_PTR_W:0]                          count_q;
  logic                                       mem_fire;
  logic                                       push;
  logic                                       pop;
  logic                                       queue_full;

  assign mem_fire   = req_full_q & mem_ready_i;
  assign push       = mem_fire & ~req_q.we;
  assign pop        = mem_result_valid_i;
  assign queue_full = (count_q == (LQ_PTR_W+1)'(LOAD_QUEUE_DEPTH));

  // Stores never need a queue slot
  assign ready_o = ~req_full_q & (~queue_full | (req_i.op == OP_STORE));

  assign mem_valid_o = req_full_q;
  assign mem_req_o   = req_q;

  // Memory result pairs with the oldest pending load
  assign wb_valid_o    = mem_result_valid_i;
  assign wb_req_o.addr = queue_q[rd_ptr_q];
  assign wb_req_o.data = mem_result_i.rdata;

  // --------------------------------------------------
  // Request register
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_full_q <= 1'b0;
    end else if (req_valid_i) begin
      req_full_q <= 1'b1;
    end else if (mem_fire) begin
      req_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_q.id    <= req_i.id;
      req_q.addr  <= req_i.operands[0] + imm_i;
      req_q.wdata <= req_i.operands[1];
      req_q.we    <= (req_i.op == OP_STORE);
      req_rd_q    <= req_i.rd;
    end
  end

  // --------------------------------------------------
  // Pending-load queue
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LQ_PTR_W'(LOAD_QUEUE_DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LQ_PTR_W'(LOAD_QUEUE_DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= req_rd_q;
    end
  end

endmodule

`default_nettype wire

// ==== fpu_ss.sv ====
// In-order FP offload for flw/fsw, sign injection and fmv; no commit, no exceptions
`timescale 1ns/1ps
`default_nettype none

module fpu_ss (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  // Issue
  input  logic                     issue_valid_i,
  output logic                     issue_ready_o,
  input  fpu_ss_pkg::issue_req_t   issue_req_i,
  output fpu_ss_pkg::issue_resp_t  issue_resp_o,

  // Memory request
  output logic                     mem_valid_o,
  input  logic                     mem_ready_i,
  output fpu_ss_pkg::mem_req_t     mem_req_o,

  // Memory result
  input  logic                     mem_result_valid_i,
  input  fpu_ss_pkg::mem_result_t  mem_result_i,

  // Integer result
  output logic                     result_valid_o,
  input  logic                     result_ready_i,
  output fpu_ss_pkg::result_t      result_o
);

  import fpu_ss_pkg::*;

  decoded_t             decoded;
  logic [1:0][XLEN-1:0] fpr_rdata;

  // Dispatch towards the units
  exec_req_t            exec_req;
  logic                 exec_valid;
  logic                 exec_ready;
  logic                 lsu_valid;
  logic                 lsu_ready;

  // Write-back requests and the granted write
  logic                 sgnj_wb_valid;
  wb_req_t              sgnj_wb_req;
  logic                 sgnj_grant;
  logic                 lsu_wb_valid;
  wb_req_t              lsu_wb_req;
  logic                 wb_valid;
  wb_req_t              wb_req;

  fpu_ss_decoder u_decoder (
    .instr_i   (issue_req_i.instr),
    .decoded_o (decoded),
    .accept_o  (issue_resp_o.accept)
  );

  fpu_ss_controller u_controller (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .issue_req_i   (issue_req_i),
    .decoded_i     (decoded),
    .fpr_rdata_i   (fpr_rdata),
    .exec_ready_i  (exec_ready),
    .lsu_ready_i   (lsu_ready),
    .exec_req_o    (exec_req),
    .exec_valid_o  (exec_valid),
    .lsu_valid_o   (lsu_valid),
    .wb_en_i       (wb_valid),
    .wb_addr_i     (wb_req.addr)
  );

  fpu_ss_regfile u_regfile (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .raddr_a_i  (decoded.rs1),
    .raddr_b_i  (decoded.rs2),
    .rdata_a_o  (fpr_rdata[0]),
    .rdata_b_o  (fpr_rdata[1]),
    .wb_valid_i (wb_valid),
    .wb_req_i   (wb_req)
  );

  fpu_ss_sgnj_unit u_sgnj_unit (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .req_valid_i    (exec_valid),
    .req_i          (exec_req),
    .ready_o        (exec_ready),
    .wb_valid_o     (sgnj_wb_valid),
    .wb_req_o       (sgnj_wb_req),
    .wb_grant_i     (sgnj_grant),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o)
  );

  fpu_ss_lsu u_lsu (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .req_valid_i        (lsu_valid),
    .req_i              (exec_req),
    .imm_i              (decoded.imm),
    .ready_o            (lsu_ready),
    .mem_valid_o        (mem_valid_o),
    .mem_ready_i        (mem_ready_i),
    .mem_req_o          (mem_req_o),
    .mem_result_valid_i (mem_result_valid_i),
    .mem_result_i       (mem_result_i),
    .wb_valid_o         (lsu_wb_valid),
    .wb_req_o           (lsu_wb_req)
  );

  fpu_ss_wb_arbiter u_wb_arbiter (
    .lsu_valid_i  (lsu_wb_valid),
    .lsu_req_i    (lsu_wb_req),
    .exec_valid_i (sgnj_wb_valid),
    .exec_req_i   (sgnj_wb_req),
    .exec_grant_o (sgnj_grant),
    .wb_valid_o   (wb_valid),
    .wb_req_o     (wb_req)
  );

endmodule

`default_nettype wire

// ==== tb_fpu_ss.sv ====
// Loads must return in request order; memory model covers 256 words and wraps on address bits 9:2
`timescale 1ns/1ps
`default_nettype none

module tb_fpu_ss;

  import fpu_ss_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int NUM_ENTRIES = 27;
  localparam int MEM_WORDS   = 256;

  typedef struct packed {
    fpu_op_e         op;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] rs0;
    logic [XLEN-1:0] exp_data;
    logic [XLEN-1:0] exp_addr;
  } stim_t;

  logic        clk_i;
  logic        arst_n_i;
  logic        issue_valid_i;
  logic        issue_ready_o;
  issue_req_t  issue_req_i;
  issue_resp_t issue_resp_o;
  logic        mem_valid_o;
  logic        mem_ready_i;
  mem_req_t    mem_req_o;
  logic        mem_result_valid_i;
  mem_result_t mem_result_i;
  logic        result_valid_o;
  logic        result_ready_i;
  result_t     result_o;

  stim_t           stim_tab [NUM_ENTRIES];
  int              n_entries;
  logic [XLEN-1:0] ref_fpr [NUM_FPR];
  logic [XLEN-1:0] mem [MEM_WORDS];
  result_t         exp_res [$];
  mem_req_t        exp_mem [$];
  mem_result_t     load_q [$];
  int              checks;
  int              errors;

  fpu_ss dut0 (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .issue_valid_i      (issue_valid_i),
    .issue_ready_o      (issue_ready_o),
    .issue_req_i        (issue_req_i),
    .issue_resp_o       (issue_resp_o),
    .mem_valid_o        (mem_valid_o),
    .mem_ready_i        (mem_ready_i),
    .mem_req_o          (mem_req_o),
    .mem_result_valid_i (mem_result_valid_i),
    .mem_result_i       (mem_result_i),
    .result_valid_o     (result_valid_o),
    .result_ready_i     (result_ready_i),
    .result_o           (result_o)
  );

  // --------------------------------------------------
  // Instruction encoding and the stimulus table
  // --------------------------------------------------
  function automatic logic [31:0] enc_rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP_FP};
  endfunction

  function automatic logic [31:0] enc_load(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, OPC_LOAD_FP};
  endfunction

  function automatic logic [31:0] enc_store(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE_FP};
  endfunction

  task automatic add_entry(input fpu_op_e op, input logic [31:0] instr,
                           input logic [31:0] rs0, input logic [31:0] exp_data,
                           input logic [31:0] exp_addr);
    stim_tab[n_entries] = '{op, instr, rs0, exp_data, exp_addr};
    n_entries++;
  endtask

  task automatic build_table();
    n_entries = 0;
    add_entry(OP_FMV_W_X, enc_rtype(F7_FMV_W_X, 5'd0, 5'd10, 3'd0, 5'd1), 32'h3FC0_0000, '0, '0);
    add_entry(OP_FMV_W_X, enc_rtype(F7_FMV_W_X, 5'd0, 5'd10, 3'd0, 5'd2), 32'hC020_0000, '0, '0);
    add_entry(OP_FMV_X_W, enc_rtype(F7_FMV_X_W, 5'd0, 5'd1, 3'd0, 5'd5), '0, 32'h3FC0_0000, '0);
    add_entry(OP_SGNJ, enc_rtype(F7_SGNJ, 5'd2, 5'd1, 3'd0, 5'd3), '0, '0, '0);
    add_entry(OP_SGNJN, enc_rtype(F7_SGNJ, 5'd2, 5'd1, 3'd1, 5'd4), '0, '0, '0);
    add_entry(OP_SGNJX, enc_rtype(F7_SGNJ, 5'd2, 5'd2, 3'd2, 5'd5), '0, '0, '0);
    add_entry(OP_FMV_X_W, enc_rtype(F7_FMV_X_W, 5'd0, 5'd3, 3'd0, 5'd6), '0, 32'hBFC0_0000, '0);
    add_entry(OP_FMV_X_W, enc_rtype(F7_FMV_X_W, 5'd0, 5'd4, 3'd0, 5'd7), '0, 32'h3FC0_0000, '0);
    add_entry(OP_FMV_X_W, enc_rtype(F7_FMV_X_W, 5'd0, 5'd5, 3'd0, 5'd8), '0, 32'h4020_0000, '0);
    // Stores with positive and negative offsets
    add_entry(OP_STORE, enc_store(5'd3, 5'd11, 12'h008), 32'h100, 32'hBFC0_0000, 32'h108);
    add_entry(OP_STORE, enc_store(5'd2, 5'd11, 12'hFFC), 32'h040, 32'hC020_0000, 32'h03C);
    // Back-to-back loads from the fill pattern
    add_entry(OP_LOAD, enc_load(5'd6, 5'd11, 12'h010), 32'h200, 32'hC184_7B3C, 32'h210);
    add_entry(OP_LOAD, enc_load(5'd7, 5'd11, 12'h014), 32'h200, 32'hC185_7A3C, 32'h214);
    add_entry(OP_LOAD, enc_load(5'd8, 5'd11, 12'hFF8), 32'h048, 32'hC110_EF3C, 32'h040);
    add_entry(OP_FMV_X_W, enc_rtype(F7_FMV_X_W, 5'd0, 5'd6, 3'd0, 5'd9), '0, 32'hC184_7B3C, '0);
    add_entry(OP_FMV_X_W, enc_rtype(F7_FMV_X_W, 5'd0, 5'd7, 3'd0, 5'd10), '0, 32'hC185_7A3C, '0);
    // Outside the kept set
    add_entry(OP_NONE, enc_rtype(7'b0000000, 5'd2, 5'd1, 3'd0, 5'd3), '0, '0, '0);
    add_entry(OP_NONE, 32'h0020_81B3, '0, '0, '0);
    add_entry(OP_NONE, enc_rtype(F7_SGNJ, 5'd2, 5'd1, 3'd3, 5'd3), '0, '0, '0);
    // Load back the word stored earlier
    add_entry(OP_LOAD, enc_load(5'd9, 5'd11, 12'h000), 32'h108, 32'hBFC0_0000, 32'h108);
    add_entry(OP_FMV_X_W, enc_rtype(F7_FMV_X_W, 5'd0, 5'd9, 3'd0, 5'd11), '0, 32'hBFC0_0000, '0);
    add_entry(OP_SGNJX, enc_rtype(F7_SGNJ, 5'd1, 5'd9, 3'd2, 5'd10), '0, '0, '0);
    add_entry(OP_FMV_X_W, enc_rtype(F7_FMV_X_W, 5'd0, 5'd10, 3'd0, 5'd12), '0, 32'hBFC0_0000, '0);
    add_entry(OP_FMV_X_W, enc_rtype(F7_FMV_X_W, 5'd0, 5'd8, 3'd0, 5'd13), '0, 32'hC110_EF3C, '0);
    add_entry(OP_STORE, enc_store(5'd10, 5'd11, 12'h004), 32'h000, 32'hBFC0_0000, 32'h004);
    add_entry(OP_SGNJN, enc_rtype(F7_SGNJ, 5'd1, 5'd2, 3'd1, 5'd11), '0, '0, '0);
    add_entry(OP_FMV_X_W, enc_rtype(F7_FMV_X_W, 5'd0, 5'd11, 3'd0, 5'd14), '0, 32'hC020_0000, '0);
  endtask

  // --------------------------------------------------
  // Reference register model and expected outputs
  // --------------------------------------------------
  task automatic record_issue(input int idx);
    stim_t           e;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [ID_W-1:0] id;
    result_t         r;
    mem_req_t        m;
    e   = stim_tab[idx];
    rd  = e.instr[11:7];
    rs1 = e.instr[19:15];
    rs2 = e.instr[24:20];
    id  = ID_W'(idx);
    r   = '{id: id, rd: rd, data: e.exp_data};
    m   = '{id: id, addr: e.exp_addr, wdata: e.exp_data, we: (e.op == OP_STORE)};
    case (e.op)
      OP_FMV_W_X: ref_fpr[rd] = e.rs0;
      OP_SGNJ:    ref_fpr[rd] = {ref_fpr[rs2][31], ref_fpr[rs1][30:0]};
      OP_SGNJN:   ref_fpr[rd] = {~ref_fpr[rs2][31], ref_fpr[rs1][30:0]};
      OP_SGNJX:   ref_fpr[rd] = {ref_fpr[rs1][31] ^ ref_fpr[rs2][31], ref_fpr[rs1][30:0]};
      OP_FMV_X_W: exp_res.push_back(r);
      OP_STORE:   exp_mem.push_back(m);
      OP_LOAD: begin
        exp_mem.push_back(m);
        ref_fpr[rd] = e.exp_data;
      end
      default: ;
    endcase
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  // Random back-pressure on both output ports
  initial begin
    @(posedge arst_n_i);
    forever begin
      @(posedge clk_i);
      #1;
      result_ready_i = ($urandom % 4) != 0;
      mem_ready_i    = ($urandom % 4) != 0;
    end
  end

  // Result port monitor
  initial begin
    result_t e;
    forever begin
      @(negedge clk_i);
      if (result_valid_o && result_ready_i) begin
        checks++;
        assert (exp_res.size() != 0) else begin
          errors++;
          $display("Error at %0t: result id %0d arrived with no instruction expecting one",
                   $time, result_o.id);
        end
        if (exp_res.size() != 0) begin
          e = exp_res.pop_front();
          assert (result_o === e) else begin
            errors++;
            $display("Mismatch at %0t: result id/rd/data %0d %0d %h, expected %0d %0d %h",
                     $time, result_o.id, result_o.rd, result_o.data, e.id, e.rd, e.data);
          end
        end
      end
    end
  end

  // Memory model with request checks and in-order load returns
  initial begin
    mem_req_t    e;
    mem_result_t lr;
    forever begin
      @(negedge clk_i);
      if (mem_valid_o && mem_ready_i) begin
        checks++;
        assert (exp_mem.size() != 0) else begin
          errors++;
          $display("Error at %0t: memory request id %0d arrived with no instruction expecting one",
                   $time, mem_req_o.id);
        end
        if (exp_mem.size() != 0) begin
          e = exp_mem.pop_front();
          assert (mem_req_o.id === e.id && mem_req_o.addr === e.addr && mem_req_o.we === e.we
                  && (!e.we || mem_req_o.wdata === e.wdata)) else begin
            errors++;
            $display("Mismatch at %0t: mem id/addr/we/wdata %0d %h %b %h, expected %0d %h %b %h",
                     $time, mem_req_o.id, mem_req_o.addr, mem_req_o.we, mem_req_o.wdata,
                     e.id, e.addr, e.we, e.wdata);
          end
        end
        if (mem_req_o.we) begin
          mem[mem_req_o.addr[9:2]] = mem_req_o.wdata;
        end else begin
          lr = '{id: mem_req_o.id, rdata: mem[mem_req_o.addr[9:2]]};
          load_q.push_back(lr);
        end
      end
    end
  end

  initial begin
    int lat;
    @(posedge arst_n_i);
    forever begin
      wait (load_q.size() != 0);
      lat = 1 + ($urandom % 4);
      repeat (lat) @(posedge clk_i);
      #1;
      mem_result_valid_i = 1'b1;
      mem_result_i       = load_q.pop_front();
      @(posedge clk_i);
      #1;
      mem_result_valid_i = 1'b0;
    end
  end

  initial begin
    #(NUM_ENTRIES * 40 * CLK_PERIOD);
    $display("Timeout at %0t: run did not finish within %0d cycles", $time, NUM_ENTRIES * 40);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(36));
    arst_n_i           = 1'b0;
    issue_valid_i      = 1'b0;
    issue_req_i        = '0;
    mem_ready_i        = 1'b0;
    mem_result_valid_i = 1'b0;
    mem_result_i       = '0;
    result_ready_i     = 1'b0;
    checks             = 0;
    errors             = 0;
    // Fill word built from the full word index
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {8'hC1, 8'(i), ~8'(i), 8'h3C};
    end
    for (int i = 0; i < NUM_FPR; i++) begin
      ref_fpr[i] = '0;
    end
    build_table();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    // Ready and both valids stay low while reset is held
    checks++;
    assert (issue_ready_o === 1'b0 && mem_valid_o === 1'b0 && result_valid_o === 1'b0) else begin
      errors++;
      $display("Mismatch at %0t: in reset ready %b mem_valid %b result_valid %b, expected 0 0 0",
               $time, issue_ready_o, mem_valid_o, result_valid_o);
    end
    @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    for (int i = 0; i < n_entries; i++) begin
      @(posedge clk_i);
      #1;
      issue_valid_i     = 1'b1;
      issue_req_i.instr = stim_tab[i].instr;
      issue_req_i.rs[0] = stim_tab[i].rs0;
      issue_req_i.rs[1] = ~stim_tab[i].rs0;
      issue_req_i.id    = ID_W'(i);
      do @(negedge clk_i); while (!issue_ready_o);
      checks++;
      assert (issue_resp_o.accept === (stim_tab[i].op != OP_NONE)) else begin
        errors++;
        $display("Mismatch at %0t: entry %0d accept %b, expected %b",
                 $time, i, issue_resp_o.accept, stim_tab[i].op != OP_NONE);
      end
      record_issue(i);
    end
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b0;

    // Drain outstanding work before the register file check
    wait (exp_res.size() == 0 && exp_mem.size() == 0 && load_q.size() == 0);
    repeat (4) @(posedge clk_i);
    for (int i = 0; i < NUM_FPR; i++) begin
      checks++;
      assert (dut0.u_regfile.regs_q[i] === ref_fpr[i]) else begin
        errors++;
        $display("Mismatch at %0t: f%0d holds %h, expected %h",
                 $time, i, dut0.u_regfile.regs_q[i], ref_fpr[i]);
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
fpu_ss_pkg.sv
fpu_ss_wb_arbiter.sv
fpu_ss_regfile.sv
fpu_ss_decoder.sv
fpu_ss_controller.sv
fpu_ss_sgnj_unit.sv
fpu_ss_lsu.sv
fpu_ss.sv
tb_fpu_ss.sv

// ==== Bender.yml ====
package:
  name: fpu_ss

sources:
  - files:
      - fpu_ss_pkg.sv
      - fpu_ss_wb_arbiter.sv
      - fpu_ss_regfile.sv
      - fpu_ss_decoder.sv
      - fpu_ss_controller.sv
      - fpu_ss_sgnj_unit.sv
      - fpu_ss_lsu.sv
      - fpu_ss.sv
  - target: test
    files:
      - tb_fpu_ss.sv
